/* src/cu_pkg.sv */
`default_nettype none

package cu_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	parameter int vertex_size_bits = 32;
	parameter int edge_size_bits   = 32;
	parameter int cu_id_bits       = 8;

	// traffic tagged with this id belongs to the vertex-job generator
	localparam logic [cu_id_bits-1:0] vertex_control_id = '1;

	//////////////////////////////
	// bus lines
	//////////////////////////////

	typedef struct packed {
		logic [31:0]           address;
		logic [cu_id_bits-1:0] cu_id;
		logic [7:0]            tag;
	} cmd_payload_t;

	typedef struct packed {
		logic         valid;
		cmd_payload_t payload;
	} cmd_line_t;

	typedef struct packed {
		logic [cu_id_bits-1:0] cu_id;
		logic [7:0]            tag;
	} response_payload_t;

	typedef struct packed {
		logic              valid;
		response_payload_t payload;
	} response_t;

	typedef struct packed {
		logic [cu_id_bits-1:0] cu_id;
		logic [7:0]            tag;
		logic [63:0]           data;
	} data_payload_t;

	typedef struct packed {
		logic          valid;
		data_payload_t payload;
	} data_line_t;

	typedef struct packed {
		logic alfull;
		logic empty;
	} buffer_status_t;

	// work descriptor
	typedef struct packed {
		logic                        valid;
		logic [vertex_size_bits-1:0] num_vertices;
		logic [edge_size_bits-1:0]   num_edges;
	} wed_t;

	typedef struct packed {
		logic [63:0] var1;
		logic [63:0] var2;
	} cu_configure_t;

	// var1 holds the vertex total, var2 the edge total
	typedef struct packed {
		logic [63:0] var1;
		logic [63:0] var2;
	} cu_return_t;

endpackage

`default_nettype wire

/* src/cu_input_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_input_stage
	import cu_pkg::*;
(
	input  wire                  clock,
	input  wire                  rstn,
	input  wire                  enabled_in,
	input  wire wed_t            wed_in,
	input  wire cu_configure_t   configure_in,
	input  wire response_t       read_response_in,
	input  wire response_t       write_response_in,
	input  wire data_line_t      read_data_0_in,
	input  wire data_line_t      read_data_1_in,
	input  wire buffer_status_t  read_status_in,
	input  wire buffer_status_t  write_status_in,
	output logic                 enabled,
	output logic                 cu_ready_q,
	output wed_t                 wed_q,
	output logic [63:0]          configure_q,
	output response_t            read_response_q,
	output response_t            write_response_q,
	output data_line_t           read_data_0_q,
	output data_line_t           read_data_1_q,
	output buffer_status_t       write_status_q
);

	// entry 0 is the read buffer, entry 1 the write buffer
	buffer_status_t [1:0] status_q;

	assign write_status_q = status_q[1];

	//////////////////////////////
	// boundary registers
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled          <= 1'b0;
			wed_q            <= '0;
			read_response_q  <= '0;
			write_response_q <= '0;
			read_data_0_q    <= '0;
			read_data_1_q    <= '0;
			status_q         <= {2{buffer_status_t'{alfull: 1'b0, empty: 1'b1}}};
		end else begin
			enabled                  <= enabled_in;
			wed_q.num_vertices       <= wed_in.num_vertices;
			wed_q.num_edges          <= wed_in.num_edges;
			read_response_q.payload  <= read_response_in.payload;
			write_response_q.payload <= write_response_in.payload;
			read_data_0_q.payload    <= read_data_0_in.payload;
			read_data_1_q.payload    <= read_data_1_in.payload;
			// strobes only pass while the unit is on
			if (enabled) begin
				wed_q.valid            <= wed_in.valid;
				read_response_q.valid  <= read_response_in.valid;
				write_response_q.valid <= write_response_in.valid;
				read_data_0_q.valid    <= read_data_0_in.valid;
				read_data_1_q.valid    <= read_data_1_in.valid;
				status_q               <= {write_status_in, read_status_in};
			end
		end
	end

	// a zero word never overwrites the configuration
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			configure_q <= '0;
			cu_ready_q  <= 1'b0;
		end else begin
			if (|configure_in.var1) begin
				configure_q <= configure_in.var1;
			end
			cu_ready_q <= (|configure_q) && wed_q.valid;
		end
	end

endmodule

`default_nettype wire

/* src/cu_response_router.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_response_router
	import cu_pkg::*;
(
	input  wire             clock,
	input  wire             rstn,
	input  wire             enabled,
	input  wire response_t  read_response_q,
	input  wire response_t  write_response_q,
	input  wire data_line_t read_data_0_q,
	input  wire data_line_t read_data_1_q,
	output response_t      vertex_response,
	output response_t      algorithm_response,
	output response_t      algorithm_write_response,
	output data_line_t     vertex_data_0,
	output data_line_t     vertex_data_1,
	output data_line_t     algorithm_data_0,
	output data_line_t     algorithm_data_1
);

	// returns {vertex valid, algorithm valid}
	function automatic logic [1:0] steer(
		input logic                  on,
		input logic                  valid,
		input logic [cu_id_bits-1:0] id
	);
		logic hit;
		hit = (id == vertex_control_id);
		return {on && valid && hit, on && valid && !hit};
	endfunction

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_response          <= '0;
			algorithm_response       <= '0;
			algorithm_write_response <= '0;
			vertex_data_0            <= '0;
			vertex_data_1            <= '0;
			algorithm_data_0         <= '0;
			algorithm_data_1         <= '0;
		end else begin
			// payload goes to both sides, only one valid is raised
			vertex_response.payload    <= read_response_q.payload;
			algorithm_response.payload <= read_response_q.payload;
			{vertex_response.valid, algorithm_response.valid} <=
				steer(enabled, read_response_q.valid, read_response_q.payload.cu_id);

			vertex_data_0.payload    <= read_data_0_q.payload;
			algorithm_data_0.payload <= read_data_0_q.payload;
			{vertex_data_0.valid, algorithm_data_0.valid} <=
				steer(enabled, read_data_0_q.valid, read_data_0_q.payload.cu_id);

			vertex_data_1.payload    <= read_data_1_q.payload;
			algorithm_data_1.payload <= read_data_1_q.payload;
			{vertex_data_1.valid, algorithm_data_1.valid} <=
				steer(enabled, read_data_1_q.valid, read_data_1_q.payload.cu_id);

			// write responses only ever belong to the algorithm units
			algorithm_write_response.payload <= write_response_q.payload;
			algorithm_write_response.valid   <= enabled && write_response_q.valid;
		end
	end

endmodule

`default_nettype wire

/* src/cu_read_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_read_arbiter
	import cu_pkg::*;
#(
	parameter int num_read_requests = 2
) (
	input  wire                                    clock,
	input  wire                                    rstn,
	input  wire                                    enabled,
	input  wire cmd_line_t [num_read_requests-1:0] command_in,
	output logic [num_read_requests-1:0]           ready,
	output cmd_line_t                              command_out
);

	localparam int ptr_bits = (num_read_requests > 1) ? $clog2(num_read_requests) : 1;

	logic [ptr_bits-1:0]          priority_ptr;
	logic [ptr_bits-1:0]          grant_idx;
	logic                         grant_found;
	logic [num_read_requests-1:0] eligible;
	logic [num_read_requests-1:0] grant_onehot;

	// a requester that holds ready this cycle still shows the command it just had granted
	always_comb begin
		for (int i = 0; i < num_read_requests; i++) begin
			eligible[i] = command_in[i].valid && !ready[i];
		end
	end

	// first eligible requester at or after the pointer
	always_comb begin
		int slot;
		grant_found  = 1'b0;
		grant_idx    = '0;
		grant_onehot = '0;
		for (int k = 0; k < num_read_requests; k++) begin
			slot = (int'(priority_ptr) + k) % num_read_requests;
			if (!grant_found && eligible[slot]) begin
				grant_found = 1'b1;
				grant_idx   = ptr_bits'(slot);
			end
		end
		if (grant_found) begin
			grant_onehot[grant_idx] = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			priority_ptr <= '0;
			ready        <= '0;
			command_out  <= '0;
		end else begin
			command_out.payload <= command_in[grant_idx].payload;
			command_out.valid   <= enabled && grant_found;
			ready               <= enabled ? grant_onehot : '0;
			// rotate past the winner
			if (enabled && grant_found) begin
				priority_ptr <= ptr_bits'((int'(grant_idx) + 1) % num_read_requests);
			end
		end
	end

endmodule

`default_nettype wire

/* src/cu_command_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_command_stage
	import cu_pkg::*;
(
	input  wire                 clock,
	input  wire                 rstn,
	input  wire                 cu_ready_q,
	input  wire buffer_status_t write_status_q,
	input  wire cmd_line_t      arbiter_command,
	input  wire cmd_line_t      write_command_in,
	input  wire data_line_t     write_data_0_in,
	input  wire data_line_t     write_data_1_in,
	input  wire                 write_request,
	output logic                write_bus_grant,
	output cmd_line_t           read_command_out,
	output cmd_line_t           write_command_out,
	output data_line_t          write_data_0_out,
	output data_line_t          write_data_1_out
);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_bus_grant   <= 1'b0;
			read_command_out  <= '0;
			write_command_out <= '0;
			write_data_0_out  <= '0;
			write_data_1_out  <= '0;
		end else begin
			// hold the writer off while the write buffer is nearly full
			write_bus_grant <= write_request && !write_status_q.alfull;

			read_command_out.payload  <= arbiter_command.payload;
			write_command_out.payload <= write_command_in.payload;
			write_data_0_out.payload  <= write_data_0_in.payload;
			write_data_1_out.payload  <= write_data_1_in.payload;

			read_command_out.valid  <= cu_ready_q && arbiter_command.valid;
			write_command_out.valid <= cu_ready_q && write_command_in.valid;
			write_data_0_out.valid  <= cu_ready_q && write_data_0_in.valid;
			write_data_1_out.valid  <= cu_ready_q && write_data_1_in.valid;
		end
	end

endmodule

`default_nettype wire

/* src/cu_done_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_done_tracker
	import cu_pkg::*;
(
	input  wire                        clock,
	input  wire                        rstn,
	input  wire                        enabled,
	input  wire                        cu_ready_q,
	input  wire wed_t                  wed_q,
	input  wire [63:0]                 configure_q,
	input  wire [vertex_size_bits-1:0] vertex_done_count,
	input  wire [vertex_size_bits-1:0] vertex_filtered_count,
	input  wire [edge_size_bits-1:0]   edge_done_count,
	output cu_return_t                 cu_return,
	output logic                       cu_done,
	output logic [63:0]                cu_status
);

	logic [vertex_size_bits-1:0] vertex_done_q;
	logic [vertex_size_bits-1:0] filtered_q;
	logic [edge_size_bits-1:0]   edge_done_q;
	logic [vertex_size_bits-1:0] vertex_total;
	logic [edge_size_bits-1:0]   edge_total;
	cu_return_t                  return_q;
	logic                        done_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_q <= '0;
			filtered_q    <= '0;
			edge_done_q   <= '0;
			vertex_total  <= '0;
			edge_total    <= '0;
			return_q      <= '0;
			done_q        <= 1'b0;
			cu_return     <= '0;
			cu_done       <= 1'b0;
			cu_status     <= '0;
		end else begin
			if (enabled) begin
				vertex_done_q <= vertex_done_count;
				filtered_q    <= vertex_filtered_count;
				edge_done_q   <= edge_done_count;
				// filtered vertices count as processed
				vertex_total  <= vertex_done_q + filtered_q;
				edge_total    <= edge_done_q;
				cu_return     <= return_q;
				cu_done       <= done_q;
				cu_status     <= configure_q;
			end
			if (cu_ready_q) begin
				return_q.var1 <= 64'(vertex_total);
				return_q.var2 <= 64'(edge_total);
				done_q        <= (wed_q.num_vertices == vertex_total) &&
					(wed_q.num_edges == edge_total);
			end
		end
	end

endmodule

`default_nettype wire

/* src/cu_control.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_control
	import cu_pkg::*;
#(
	parameter int num_read_requests = 2
) (
	input  wire                        clock,
	input  wire                        rstn,
	input  wire                        enabled_in,
	input  wire wed_t                  wed_in,
	input  wire cu_configure_t         configure_in,
	input  wire response_t             read_response_in,
	input  wire response_t             write_response_in,
	input  wire data_line_t            read_data_0_in,
	input  wire data_line_t            read_data_1_in,
	input  wire buffer_status_t        read_status_in,
	input  wire buffer_status_t        write_status_in,
	// vertex-job generator side
	input  wire cmd_line_t             vertex_read_command,
	output logic                       vertex_ready,
	output response_t                  vertex_response,
	output data_line_t                 vertex_data_0,
	output data_line_t                 vertex_data_1,
	// algorithm units side
	input  wire cmd_line_t             algorithm_read_command,
	output logic                       algorithm_ready,
	output response_t                  algorithm_response,
	output response_t                  algorithm_write_response,
	output data_line_t                 algorithm_data_0,
	output data_line_t                 algorithm_data_1,
	input  wire                        write_request,
	output logic                       write_bus_grant,
	input  wire cmd_line_t             write_command_in,
	input  wire data_line_t            write_data_0_in,
	input  wire data_line_t            write_data_1_in,
	// job counters
	input  wire [vertex_size_bits-1:0] vertex_done_count,
	input  wire [vertex_size_bits-1:0] vertex_filtered_count,
	input  wire [edge_size_bits-1:0]   edge_done_count,
	// memory interface
	output cmd_line_t                  read_command_out,
	output cmd_line_t                  write_command_out,
	output data_line_t                 write_data_0_out,
	output data_line_t                 write_data_1_out,
	output cu_return_t                 cu_return,
	output logic                       cu_done,
	output logic [63:0]                cu_status
);

	logic                               enabled;
	logic                               cu_ready_q;
	wed_t                               wed_q;
	logic [63:0]                        configure_q;
	response_t                          read_response_q;
	response_t                          write_response_q;
	data_line_t                         read_data_0_q;
	data_line_t                         read_data_1_q;
	buffer_status_t                     write_status_q;
	cmd_line_t [num_read_requests-1:0]  read_requests;
	logic [num_read_requests-1:0]       read_ready;
	cmd_line_t                          arbiter_command;

	// vertex client is requester 0
	assign read_requests[0] = vertex_read_command;
	assign read_requests[1] = algorithm_read_command;
	assign vertex_ready     = read_ready[0];
	assign algorithm_ready  = read_ready[1];

	cu_input_stage cu_input_stage_i (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled_in),
		.wed_in           (wed_in),
		.configure_in     (configure_in),
		.read_response_in (read_response_in),
		.write_response_in(write_response_in),
		.read_data_0_in   (read_data_0_in),
		.read_data_1_in   (read_data_1_in),
		.read_status_in   (read_status_in),
		.write_status_in  (write_status_in),
		.enabled          (enabled),
		.cu_ready_q       (cu_ready_q),
		.wed_q            (wed_q),
		.configure_q      (configure_q),
		.read_response_q  (read_response_q),
		.write_response_q (write_response_q),
		.read_data_0_q    (read_data_0_q),
		.read_data_1_q    (read_data_1_q),
		.write_status_q   (write_status_q)
	);

	cu_response_router cu_response_router_i (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled                 (enabled),
		.read_response_q         (read_response_q),
		.write_response_q        (write_response_q),
		.read_data_0_q           (read_data_0_q),
		.read_data_1_q           (read_data_1_q),
		.vertex_response         (vertex_response),
		.algorithm_response      (algorithm_response),
		.algorithm_write_response(algorithm_write_response),
		.vertex_data_0           (vertex_data_0),
		.vertex_data_1           (vertex_data_1),
		.algorithm_data_0        (algorithm_data_0),
		.algorithm_data_1        (algorithm_data_1)
	);

	cu_read_arbiter #(
		.num_read_requests(num_read_requests)
	) cu_read_arbiter_i (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (cu_ready_q),
		.command_in (read_requests),
		.ready      (read_ready),
		.command_out(arbiter_command)
	);

	cu_command_stage cu_command_stage_i (
		.clock            (clock),
		.rstn             (rstn),
		.cu_ready_q       (cu_ready_q),
		.write_status_q   (write_status_q),
		.arbiter_command  (arbiter_command),
		.write_command_in (write_command_in),
		.write_data_0_in  (write_data_0_in),
		.write_data_1_in  (write_data_1_in),
		.write_request    (write_request),
		.write_bus_grant  (write_bus_grant),
		.read_command_out (read_command_out),
		.write_command_out(write_command_out),
		.write_data_0_out (write_data_0_out),
		.write_data_1_out (write_data_1_out)
	);

	cu_done_tracker cu_done_tracker_i (
		.clock                (clock),
		.rstn                 (rstn),
		.enabled              (enabled),
		.cu_ready_q           (cu_ready_q),
		.wed_q                (wed_q),
		.configure_q          (configure_q),
		.vertex_done_count    (vertex_done_count),
		.vertex_filtered_count(vertex_filtered_count),
		.edge_done_count      (edge_done_count),
		.cu_return            (cu_return),
		.cu_done              (cu_done),
		.cu_status            (cu_status)
	);

endmodule

`default_nettype wire

/* verif/cu_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_clock_gen #(
	parameter int period       = 8,
	parameter int reset_cycles = 2
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// release just after an edge
	initial begin
		rstn = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		#1 rstn = 1'b1;
	end

endmodule

`default_nettype wire

/* verif/cu_control_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_control_tb
	import cu_pkg::*;
();

	localparam int period     = 8;
	localparam int num_cycles = 200;
	localparam int timeout_ns = num_cycles * 20 * period;
	localparam int max_cmds   = 40;

	logic clock;
	logic rstn;
	integer seed = 32'h5238_fe8b;

	logic enabled_in;
	logic write_request;
	wed_t wed_in;
	cu_configure_t configure_in;
	response_t read_response_in, write_response_in;
	data_line_t read_data_0_in, read_data_1_in, write_data_0_in, write_data_1_in;
	buffer_status_t read_status_in, write_status_in;
	cmd_line_t vertex_read_command, algorithm_read_command, write_command_in;
	logic [vertex_size_bits-1:0] vertex_done_count, vertex_filtered_count;
	logic [edge_size_bits-1:0] edge_done_count;

	logic vertex_ready, algorithm_ready, write_bus_grant, cu_done;
	response_t vertex_response, algorithm_response, algorithm_write_response;
	data_line_t vertex_data_0, vertex_data_1, algorithm_data_0, algorithm_data_1;
	data_line_t write_data_0_out, write_data_1_out;
	cmd_line_t read_command_out, write_command_out;
	cu_return_t cu_return;
	logic [63:0] cu_status;

	//////////////////////////////
	// reference model state
	//////////////////////////////

	response_t prev_read_response, prev_write_response;
	data_line_t prev_data_0, prev_data_1;
	logic prev_alfull;
	logic [63:0] config_model;
	logic [vertex_size_bits-1:0] vdone_hist [3];
	logic [vertex_size_bits-1:0] vfilt_hist [3];
	logic [edge_size_bits-1:0] edge_hist [3];
	// read commands per client, bit 31 of the address names the client
	cmd_line_t cmds [2][max_cmds];
	int num_cmds [2];
	int drive_idx [2];
	int port_idx [2];
	// a client may rest for a cycle after its ready pulse
	int idle_cycles [2];
	// -1 until the first grant
	int last_winner;

	cu_clock_gen #(.period(period), .reset_cycles(2)) cu_clock_gen_i (
		.clock(clock),
		.rstn (rstn)
	);

	cu_control #(.num_read_requests(2)) cu_control_i (.*);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_cmd(input cmd_line_t got, input cmd_line_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_response(input response_t got, input response_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_data(input data_line_t got, input data_line_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_return(input cu_return_t got, input cu_return_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_word(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// a quarter of the traffic is tagged for the vertex side
	function automatic logic [cu_id_bits-1:0] random_id();
		if (($random(seed) & 3) == 0)
			return vertex_control_id;
		return cu_id_bits'($random(seed));
	endfunction

	function automatic response_t random_response();
		response_t r;
		r.valid         = 1'($random(seed));
		r.payload.cu_id = random_id();
		r.payload.tag   = 8'($random(seed));
		return r;
	endfunction

	function automatic data_line_t random_data();
		data_line_t d;
		d.valid         = 1'($random(seed));
		d.payload.cu_id = random_id();
		d.payload.tag   = 8'($random(seed));
		d.payload.data  = {$random(seed), $random(seed)};
		return d;
	endfunction

	function automatic response_t routed_response(input response_t x, input logic vertex_side);
		response_t r;
		r       = x;
		r.valid = x.valid && ((x.payload.cu_id == vertex_control_id) == vertex_side);
		return r;
	endfunction

	function automatic data_line_t routed_data(input data_line_t x, input logic vertex_side);
		data_line_t r;
		r       = x;
		r.valid = x.valid && ((x.payload.cu_id == vertex_control_id) == vertex_side);
		return r;
	endfunction

	function automatic cmd_line_t next_command(input int c);
		if (idle_cycles[c] == 0 && drive_idx[c] < num_cmds[c])
			return cmds[c][drive_idx[c]];
		return '0;
	endfunction

	task automatic build_commands();
		num_cmds[0] = max_cmds;
		num_cmds[1] = max_cmds - 12;
		for (int c = 0; c < 2; c++) begin
			drive_idx[c]   = 0;
			port_idx[c]    = 0;
			idle_cycles[c] = 0;
			for (int k = 0; k < max_cmds; k++) begin
				cmds[c][k].valid           = 1'b1;
				cmds[c][k].payload.address = {1'(c), 31'($random(seed))};
				cmds[c][k].payload.cu_id   = random_id();
				cmds[c][k].payload.tag     = 8'(k);
			end
		end
	endtask

	//////////////////////////////
	// per-cycle checks
	//////////////////////////////

	task automatic check_idle();
		check_bit(vertex_response.valid | algorithm_response.valid |
			algorithm_write_response.valid, 1'b0, "a routed response valid");
		check_bit(vertex_data_0.valid | vertex_data_1.valid | algorithm_data_0.valid |
			algorithm_data_1.valid, 1'b0, "a routed data valid");
		check_bit(vertex_ready | algorithm_ready | write_bus_grant, 1'b0,
			"a ready pulse or write_bus_grant");
		check_bit(read_command_out.valid | write_command_out.valid | write_data_0_out.valid |
			write_data_1_out.valid, 1'b0, "a command or write data valid");
		check_bit(cu_done, 1'b0, "cu_done");
		check_word(cu_status, '0, "cu_status");
	endtask

	task automatic check_outputs();
		logic [vertex_size_bits-1:0] total;
		cu_return_t exp_return;
		// routed streams carry the inputs of the previous cycle
		check_response(vertex_response, routed_response(prev_read_response, 1'b1),
			"vertex_response");
		check_response(algorithm_response, routed_response(prev_read_response, 1'b0),
			"algorithm_response");
		check_response(algorithm_write_response, prev_write_response, "algorithm_write_response");
		check_data(vertex_data_0, routed_data(prev_data_0, 1'b1), "vertex_data_0");
		check_data(vertex_data_1, routed_data(prev_data_1, 1'b1), "vertex_data_1");
		check_data(algorithm_data_0, routed_data(prev_data_0, 1'b0), "algorithm_data_0");
		check_data(algorithm_data_1, routed_data(prev_data_1, 1'b0), "algorithm_data_1");
		// write side
		check_bit(write_bus_grant, write_request && !prev_alfull, "write_bus_grant");
		check_cmd(write_command_out, write_command_in, "write_command_out");
		check_data(write_data_0_out, write_data_0_in, "write_data_0_out");
		check_data(write_data_1_out, write_data_1_in, "write_data_1_out");
		// counters from three cycles back
		total           = vdone_hist[2] + vfilt_hist[2];
		exp_return.var1 = 64'(total);
		exp_return.var2 = 64'(edge_hist[2]);
		check_return(cu_return, exp_return, "cu_return");
		check_bit(cu_done, (total == wed_in.num_vertices) && (edge_hist[2] == wed_in.num_edges),
			"cu_done");
		check_word(cu_status, config_model, "cu_status");
	endtask

	task automatic check_read_port();
		int c;
		if (read_command_out.valid) begin
			c = int'(read_command_out.payload.address[31]);
			if (port_idx[c] >= num_cmds[c])
				abort_run($sformatf("an extra read command from client %0d reached the port", c));
			check_cmd(read_command_out, cmds[c][port_idx[c]],
				$sformatf("read command %0d of client %0d", port_idx[c], c));
			port_idx[c]++;
		end
	endtask

	// the pending levels seen here are the ones the arbiter sampled for this grant
	task automatic serve_clients();
		logic [1:0] ready_now;
		logic [1:0] pending;
		ready_now = {algorithm_ready, vertex_ready};
		pending   = {algorithm_read_command.valid, vertex_read_command.valid};
		if (ready_now == 2'b11)
			abort_run("both clients got a ready pulse in the same cycle");
		for (int c = 0; c < 2; c++) begin
			if (ready_now[c]) begin
				if (!pending[c])
					abort_run($sformatf("client %0d got a ready pulse with nothing pending", c));
				if (last_winner == c && pending[1-c])
					abort_run($sformatf("client %0d won twice in a row while client %0d waited",
						c, 1 - c));
				last_winner = c;
				drive_idx[c]++;
				idle_cycles[c] = int'($random(seed) & 1);
			end
		end
	endtask

	task automatic update_models();
		prev_read_response  = read_response_in;
		prev_write_response = write_response_in;
		prev_data_0         = read_data_0_in;
		prev_data_1         = read_data_1_in;
		prev_alfull         = write_status_in.alfull;
		if (|configure_in.var1)
			config_model = configure_in.var1;
		for (int i = 2; i > 0; i--) begin
			vdone_hist[i] = vdone_hist[i-1];
			vfilt_hist[i] = vfilt_hist[i-1];
			edge_hist[i]  = edge_hist[i-1];
		end
		vdone_hist[0] = vertex_done_count;
		vfilt_hist[0] = vertex_filtered_count;
		edge_hist[0]  = edge_done_count;
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic drive_inputs(input int mode);
		enabled_in             = (mode != 0);
		read_response_in       = random_response();
		write_response_in      = random_response();
		read_data_0_in         = random_data();
		read_data_1_in         = random_data();
		read_status_in         = buffer_status_t'(2'($random(seed)));
		write_status_in.alfull = (($random(seed) & 3) == 0);
		write_status_in.empty  = 1'($random(seed));
		if (mode != 0) begin
			// mostly zero words, which the unit must ignore
			if (($random(seed) & 7) == 0)
				configure_in.var1 = {$random(seed), $random(seed)} | 64'd1;
			else
				configure_in.var1 = '0;
			write_request            = (($random(seed) & 7) != 0);
			write_command_in.valid   = write_bus_grant && 1'($random(seed));
			write_command_in.payload = {$random(seed), random_id(), 8'($random(seed))};
			write_data_0_in          = random_data();
			write_data_0_in.valid    = write_data_0_in.valid && write_bus_grant;
			write_data_1_in          = random_data();
			write_data_1_in.valid    = write_data_1_in.valid && write_bus_grant;
			vertex_read_command      = next_command(0);
			algorithm_read_command   = next_command(1);
			for (int c = 0; c < 2; c++) begin
				if (idle_cycles[c] > 0)
					idle_cycles[c]--;
			end
			vertex_done_count        = $random(seed);
			edge_done_count          = $random(seed);
			if (($random(seed) & 3) == 0) begin
				vertex_filtered_count = wed_in.num_vertices - vertex_done_count;
				edge_done_count       = wed_in.num_edges;
			end else begin
				vertex_filtered_count = $random(seed);
			end
		end
	endtask

	// mode 0 disabled, 1 warm-up, 2 fully checked
	task automatic run_cycle(input int mode);
		@(posedge clock);
		#1;
		if (mode == 0)
			check_idle();
		if (mode == 2)
			check_outputs();
		if (mode != 0) begin
			check_read_port();
			serve_clients();
		end
		update_models();
		drive_inputs(mode);
	endtask

	initial begin
		#(timeout_ns);
		$display("test timed out: the run did not finish within %0d ns", timeout_ns);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

	initial begin
		enabled_in             = 1'b0;
		write_request          = 1'b0;
		read_response_in       = '0;
		write_response_in      = '0;
		read_data_0_in         = '0;
		read_data_1_in         = '0;
		write_data_0_in        = '0;
		write_data_1_in        = '0;
		read_status_in         = '0;
		write_status_in        = '0;
		vertex_read_command    = '0;
		algorithm_read_command = '0;
		write_command_in       = '0;
		vertex_done_count      = '0;
		vertex_filtered_count  = '0;
		edge_done_count        = '0;
		config_model           = '0;
		last_winner            = -1;
		// descriptor and configuration first, enable later
		wed_in.valid           = 1'b1;
		wed_in.num_vertices    = $random(seed);
		wed_in.num_edges       = $random(seed);
		configure_in.var1      = {$random(seed), $random(seed)} | 64'd1;
		configure_in.var2      = {$random(seed), $random(seed)};
		build_commands();
		@(posedge rstn);
		repeat (6) run_cycle(0);
		repeat (8) run_cycle(1);
		repeat (num_cycles) run_cycle(2);
		while (port_idx[0] < num_cmds[0] || port_idx[1] < num_cmds[1]) begin
			run_cycle(2);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

/* cu_control.f */
src/cu_pkg.sv
src/cu_input_stage.sv
src/cu_response_router.sv
src/cu_read_arbiter.sv
src/cu_command_stage.sv
src/cu_done_tracker.sv
src/cu_control.sv
verif/cu_clock_gen.sv
verif/cu_control_tb.sv

/* Bender.yml */
package:
  name: cu_control

sources:
  - src/cu_pkg.sv
  - src/cu_input_stage.sv
  - src/cu_response_router.sv
  - src/cu_read_arbiter.sv
  - src/cu_command_stage.sv
  - src/cu_done_tracker.sv
  - src/cu_control.sv
  - target: test
    files:
      - verif/cu_clock_gen.sv
      - verif/cu_control_tb.sv
